//--- src.f
hw/cache_geom_pkg.sv
hw/cache_bus_pkg.sv
hw/sweep_counter.sv
hw/lru_store.sv
hw/way_store.sv
hw/cache_fsm.sv
hw/read_cache.sv
tests/read_cache_checker.sv
tests/read_cache_tb.sv

//--- Makefile
# Verilator lint and simulation for the read cache
VERILATOR := verilator
FLAGS     := --timing --assert
TOP       := read_cache_tb
FILELIST  := src.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := *** PASSED ***

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tests/read_cache_tb.sv
// Testbench for the read cache: random reads checked against a reference
// model, with a memory responder of random latency and a watchdog.
`default_nettype none

module read_cache_tb;

  localparam int half_period = 50;
  localparam int total_reqs = 1007;
  localparam int mem_depth = 1 << cache_geom_pkg::mem_addr_w;

  logic clk;
  logic rst;
  logic req_valid;
  logic req_ready;
  logic rsp_valid;
  logic rsp_ready;
  cache_bus_pkg::cache_req_t req;
  cache_bus_pkg::cache_rsp_t rsp;
  cache_bus_pkg::mem_req_t   mem_req;
  cache_bus_pkg::mem_rsp_t   mem_rsp;

  logic [cache_geom_pkg::word_w-1:0]     mem_words [mem_depth];
  cache_geom_pkg::tag_t                  model_tag [cache_geom_pkg::num_sets][2];
  logic [1:0]                            model_valid [cache_geom_pkg::num_sets];
  logic                                  model_lru [cache_geom_pkg::num_sets];
  cache_geom_pkg::cache_addr_t           addr_q [$];
  logic [cache_geom_pkg::byte_w-1:0]     exp_q [$];
  logic [cache_geom_pkg::mem_addr_w-1:0] miss_addr;
  logic [cache_geom_pkg::mem_addr_w-1:0] stb_addr;
  logic [cache_geom_pkg::byte_w-1:0]     held_data;
  logic last_miss;
  logic stb_prev;
  logic held_prev;
  int mem_wait;
  int max_delay;
  int hold_pct;
  int errors;
  int tests_failed;
  int misses;
  int strobes;
  int acks;
  int delivered;

  initial clk = 1'b0;
  always #(half_period) clk = ~clk;

  read_cache uut (.*);

  function automatic cache_geom_pkg::cache_addr_t make_addr(input int tag, input int index,
                                                             input int offset);
    cache_geom_pkg::cache_addr_t a;
    a.fields.tag = cache_geom_pkg::tag_t'(tag);
    a.fields.index = cache_geom_pkg::index_t'(index);
    a.fields.offset = cache_geom_pkg::offset_t'(offset);
    return a;
  endfunction

  // few tags per set so that hits and evictions both occur
  task automatic queue_random(input int count);
    repeat (count) begin
      addr_q.push_back(make_addr($urandom_range(3, 0), $urandom_range(31, 0),
                                 $urandom_range(3, 0)));
    end
  endtask

  // reference cache, updated in request order
  task automatic predict(input cache_geom_pkg::cache_addr_t a);
    int idx;
    int way;
    logic [cache_geom_pkg::word_w-1:0] word;
    idx = int'(a.fields.index);
    way = int'(model_lru[idx]);
    last_miss = 1'b1;
    for (int w = 0; w < 2; w++) begin
      if (model_valid[idx][w] && model_tag[idx][w] == a.fields.tag) begin
        way = w;
        last_miss = 1'b0;
      end
    end
    if (last_miss) begin
      model_valid[idx][way] = 1'b1;
      model_tag[idx][way] = a.fields.tag;
      miss_addr = {a.fields.tag, a.fields.index};
      misses++;
    end
    // next victim is the way not just used
    model_lru[idx] = (way == 0);
    // offset 0 picks the most significant byte
    word = mem_words[{a.fields.tag, a.fields.index}];
    exp_q.push_back(word[(3 - int'(a.fields.offset)) * 8 +: 8]);
  endtask

  // inputs change on the falling edge, outputs are read a little later
  task automatic run_cycle();
    logic [cache_geom_pkg::byte_w-1:0] exp;
    @(negedge clk);
    mem_rsp = '{ack: 1'b0, data: $urandom};
    if (mem_req.stb) begin
      if (mem_wait < 0) begin
        mem_wait = $urandom_range(max_delay - 1, 0);
      end
      if (mem_wait == 0) begin
        mem_rsp = '{ack: 1'b1, data: mem_words[mem_req.addr]};
        acks++;
      end
      mem_wait--;
    end
    req_valid = (addr_q.size() > 0);
    if (req_valid) begin
      req.addr = addr_q[0];
    end
    rsp_ready = ($urandom_range(99, 0) >= hold_pct);
    #(half_period / 5);
    if (held_prev) begin
      assert (rsp_valid && rsp.data == held_data) else begin
        $display("Error: rsp.data %h held, now %h with rsp_valid %h",
                 held_data, rsp.data, rsp_valid);
        errors++;
      end
    end
    if (rsp_valid && rsp_ready) begin
      delivered++;
      assert (exp_q.size() > 0) else begin
        $display("response delivered with no request outstanding");
        errors++;
      end
      if (exp_q.size() > 0) begin
        exp = exp_q.pop_front();
        assert (rsp.data == exp) else begin
          $display("Error: rsp.data %h, expected %h", rsp.data, exp);
          errors++;
        end
      end
    end
    if (req_valid && req_ready) begin
      predict(addr_q.pop_front());
    end
    if (mem_req.stb && !stb_prev) begin
      strobes++;
      stb_addr = mem_req.addr;
      assert (last_miss && mem_req.addr == miss_addr) else begin
        $display("Error: mem_req.addr %h, expected %h, miss predicted %h",
                 mem_req.addr, miss_addr, last_miss);
        errors++;
      end
      last_miss = 1'b0;
    end
    stb_prev = mem_req.stb;
    held_prev = rsp_valid && !rsp_ready;
    held_data = rsp.data;
  endtask

  task automatic drain_requests();
    while (addr_q.size() > 0 || exp_q.size() > 0) begin
      run_cycle();
    end
  endtask

  task automatic report_test(input int num, input string name, input int errs_before);
    if (errors == errs_before) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: %0d failed checks", num, name, errors - errs_before);
      tests_failed++;
    end
  endtask

  initial begin
    cache_geom_pkg::cache_addr_t a_addr;
    cache_geom_pkg::cache_addr_t b_addr;
    int errs;
    int sweep_cycles;
    int base;
    int set_idx;
    rst = 1'b1;
    req_valid = 1'b0;
    req = '0;
    rsp_ready = 1'b1;
    mem_rsp = '0;
    stb_prev = 1'b0;
    held_prev = 1'b0;
    last_miss = 1'b0;
    mem_wait = -1;
    max_delay = 2;
    hold_pct = 0;
    void'($urandom(49013));
    for (int i = 0; i < mem_depth; i++) begin
      mem_words[i] = $urandom;
    end
    for (int s = 0; s < cache_geom_pkg::num_sets; s++) begin
      model_valid[s] = '0;
      model_lru[s] = 1'b0;
    end

    errs = errors;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    sweep_cycles = 0;
    while (!req_ready && sweep_cycles < 64) begin
      assert (!mem_req.stb && !rsp_valid) else begin
        $display("strobe or response seen during the sweep");
        errors++;
      end
      sweep_cycles++;
      @(negedge clk);
    end
    assert (sweep_cycles == 32) else begin
      $display("Error: req_ready low for %h cycles, expected %h", sweep_cycles, 32);
      errors++;
    end
    queue_random(1);
    drain_requests();
    report_test(1, "sweep", errs);

    errs = errors;
    queue_random(400);
    drain_requests();
    report_test(2, "data", errs);

    errs = errors;
    queue_random(200);
    drain_requests();
    assert (strobes == misses) else begin
      $display("Error: strobe count %h, predicted misses %h", strobes, misses);
      errors++;
    end
    report_test(3, "hit and miss", errs);

    // A, B, A, C leaves A and C in the set, so A hits and B misses
    errs = errors;
    set_idx = $urandom_range(31, 0);
    a_addr = make_addr(256, set_idx, 1);
    b_addr = make_addr(257, set_idx, 2);
    addr_q = '{a_addr, b_addr, a_addr, make_addr(258, set_idx, 3)};
    drain_requests();
    base = strobes;
    addr_q = '{a_addr, b_addr};
    drain_requests();
    assert (strobes - base == 1 && stb_addr == {b_addr.fields.tag, b_addr.fields.index})
    else begin
      $display("Error: strobes %h, mem_req.addr %h, expected 1 strobe at %h", strobes - base,
               stb_addr, {b_addr.fields.tag, b_addr.fields.index});
      errors++;
    end
    report_test(4, "replacement", errs);

    errs = errors;
    hold_pct = 50;
    base = delivered;
    queue_random(200);
    drain_requests();
    assert (delivered - base == 200) else begin
      $display("Error: responses delivered %h, expected %h", delivered - base, 200);
      errors++;
    end
    report_test(5, "back-pressure", errs);

    errs = errors;
    max_delay = 6;
    hold_pct = 20;
    queue_random(200);
    drain_requests();
    assert (acks == strobes && strobes == misses) else begin
      $display("Error: acks %h, strobes %h, misses %h", acks, strobes, misses);
      errors++;
    end
    report_test(6, "latency", errs);

    $display("tests run 6, tests failed %0d, failed checks %0d", tests_failed, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // limit scales with the number of requests in all tests
  initial begin
    repeat (40 + total_reqs * 20) @(posedge clk);
    $display("watchdog expired, the run did not finish in time");
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/read_cache_checker.sv
// Protocol assertions for the read cache, bound into read_cache.
// Covers the memory strobe, response hold under back-pressure and the sweep.
`default_nettype none

module read_cache_checker (
  input logic                      clk,
  input logic                      rst,
  input logic                      req_ready,
  input logic                      rsp_valid,
  input logic                      rsp_ready,
  input cache_bus_pkg::cache_rsp_t rsp,
  input cache_bus_pkg::mem_req_t   mem_req,
  input cache_bus_pkg::mem_rsp_t   mem_rsp,
  input cache_bus_pkg::fsm_state_t state
);

  // strobe only drops after the acknowledge
  stb_held_until_ack : assert property (
    @(posedge clk) disable iff (rst)
    mem_req.stb && !mem_rsp.ack |=> mem_req.stb
  ) else $error("memory strobe dropped before the acknowledge");

  rsp_stable : assert property (
    @(posedge clk) disable iff (rst)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp.data)
  ) else $error("response dropped or changed under back-pressure");

  // no requests until every line has been invalidated
  no_req_in_sweep : assert property (
    @(posedge clk) disable iff (rst)
    state == cache_bus_pkg::st_sweep |-> !req_ready
  ) else $error("req_ready high during the sweep");

endmodule

bind read_cache read_cache_checker u_checker (
  .clk       (clk),
  .rst       (rst),
  .req_ready (req_ready),
  .rsp_valid (rsp_valid),
  .rsp_ready (rsp_ready),
  .rsp       (rsp),
  .mem_req   (mem_req),
  .mem_rsp   (mem_rsp),
  .state     (state)
);

`default_nettype wire

//--- hw/read_cache.sv
// Top of the two-way read-only cache. Client requests come in over
// valid/ready, misses go out to a strobe/acknowledge word memory.
`default_nettype none

module read_cache (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      req_valid,
  output logic                      req_ready,
  input  cache_bus_pkg::cache_req_t req,
  output logic                      rsp_valid,
  input  logic                      rsp_ready,
  output cache_bus_pkg::cache_rsp_t rsp,
  output cache_bus_pkg::mem_req_t   mem_req,
  input  cache_bus_pkg::mem_rsp_t   mem_rsp
);

  cache_bus_pkg::fsm_state_t state;
  cache_geom_pkg::index_t    sweep_index;
  cache_geom_pkg::index_t    lru_wr_index;

  logic sweep_done;
  logic sweeping;
  logic accept;
  logic read_en;
  logic fill_en;
  logic lru_update;
  logic hit;
  logic hit_way;
  logic victim_way;

  assign accept = req_valid && req_ready;
  assign sweeping = (state == cache_bus_pkg::st_sweep);

  // replacement bits follow the sweep, then the held request's set
  assign lru_wr_index = sweeping ? sweep_index
                                 : mem_req.addr[cache_geom_pkg::index_w-1:0];

  cache_fsm u_fsm (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .rsp_ready  (rsp_ready),
    .rsp_valid  (rsp_valid),
    .hit        (hit),
    .sweep_done (sweep_done),
    .mem_ack    (mem_rsp.ack),
    .mem_stb    (mem_req.stb),
    .state      (state),
    .read_en    (read_en),
    .fill_en    (fill_en),
    .lru_update (lru_update)
  );

  sweep_counter u_sweep (
    .clk         (clk),
    .rst         (rst),
    .sweep_index (sweep_index),
    .sweep_done  (sweep_done)
  );

  way_store u_ways (
    .clk         (clk),
    .req_addr    (req.addr),
    .accept      (accept),
    .read_en     (read_en),
    .fill_en     (fill_en),
    .sweeping    (sweeping),
    .sweep_index (sweep_index),
    .victim_way  (victim_way),
    .mem_data    (mem_rsp.data),
    .hit         (hit),
    .hit_way     (hit_way),
    .rsp_data    (rsp.data),
    .miss_addr   (mem_req.addr)
  );

  lru_store u_lru (
    .clk         (clk),
    .read_index  (req.addr.fields.index),
    .read_en     (accept),
    .write_index (lru_wr_index),
    .write_en    (lru_update),
    .used_way    (hit_way),
    .clear       (sweeping),
    .victim_way  (victim_way)
  );

endmodule

`default_nettype wire

//--- hw/cache_fsm.sv
// Controller for the read cache: sequences the reset sweep, lookups,
// the wait for memory and the refill re-read, and drives the handshakes.
`default_nettype none

module cache_fsm (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     req_valid,
  output logic                     req_ready,
  input  logic                     rsp_ready,
  output logic                     rsp_valid,
  input  logic                     hit,
  input  logic                     sweep_done,
  input  logic                     mem_ack,
  output logic                     mem_stb,
  output cache_bus_pkg::fsm_state_t state,
  output logic                     read_en,
  output logic                     fill_en,
  output logic                     lru_update
);

  cache_bus_pkg::fsm_state_t state_next;

  // a request has been accepted and its response not yet delivered
  logic pending;
  logic accept;
  logic deliver;
  logic in_run;

  assign in_run = (state == cache_bus_pkg::st_run);

  // take a new request only if the current one can leave this cycle
  assign req_ready = in_run && rsp_ready && (!pending || hit);
  assign rsp_valid = in_run && pending && hit;

  assign accept = req_valid && req_ready;
  assign deliver = rsp_valid && rsp_ready;

  // lookup on accept, second lookup once the line is written
  assign read_en = accept || (state == cache_bus_pkg::st_refill);

  assign mem_stb = (state == cache_bus_pkg::st_miss_wait);
  assign fill_en = mem_stb && mem_ack;

  // every delivered response touches its set, refills included
  assign lru_update = deliver;

  always_comb begin
    state_next = state;
    case (state)
      cache_bus_pkg::st_sweep: begin
        if (sweep_done) begin
          state_next = cache_bus_pkg::st_run;
        end
      end
      cache_bus_pkg::st_run: begin
        // lookup result is valid one cycle after accept
        if (pending && !hit) begin
          state_next = cache_bus_pkg::st_miss_wait;
        end
      end
      cache_bus_pkg::st_miss_wait: begin
        if (mem_ack) begin
          state_next = cache_bus_pkg::st_refill;
        end
      end
      cache_bus_pkg::st_refill: begin
        state_next = cache_bus_pkg::st_run;
      end
      default: begin
        state_next = cache_bus_pkg::st_sweep;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= cache_bus_pkg::st_sweep;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= 1'b0;
    end else if (accept) begin
      pending <= 1'b1;
    end else if (deliver) begin
      pending <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- hw/way_store.sv
// Valid, tag and data arrays for both ways. Reads are registered and the
// hit check and byte select work on the read result and the held request.
`default_nettype none

module way_store (
  input  logic                                  clk,
  input  cache_geom_pkg::cache_addr_t           req_addr,
  input  logic                                  accept,
  input  logic                                  read_en,
  input  logic                                  fill_en,
  input  logic                                  sweeping,
  input  cache_geom_pkg::index_t                sweep_index,
  input  logic                                  victim_way,
  input  logic [cache_geom_pkg::word_w-1:0]     mem_data,
  output logic                                  hit,
  output logic                                  hit_way,
  output logic [cache_geom_pkg::byte_w-1:0]     rsp_data,
  output logic [cache_geom_pkg::mem_addr_w-1:0] miss_addr
);

  // held request for the compare, the refill and the byte pick
  cache_geom_pkg::cache_addr_t req_q;
  cache_geom_pkg::index_t      set_index;
  cache_geom_pkg::offset_t     byte_sel;

  logic [1:0]                        way_hit;
  logic [cache_geom_pkg::word_w-1:0] line_word;

  always_ff @(posedge clk) begin
    if (accept) begin
      req_q <= req_addr;
    end
  end

  always_comb begin
    if (sweeping) begin
      set_index = sweep_index;
    end else if (accept) begin
      set_index = req_addr.fields.index;
    end else begin
      set_index = req_q.fields.index;
    end
  end

  for (genvar w = 0; w < 2; w++) begin : g_way
    logic                              valid_mem [cache_geom_pkg::num_sets];
    cache_geom_pkg::tag_t              tag_mem [cache_geom_pkg::num_sets];
    logic [cache_geom_pkg::word_w-1:0] data_mem [cache_geom_pkg::num_sets];
    logic                              valid_rd;
    cache_geom_pkg::tag_t              tag_rd;
    logic [cache_geom_pkg::word_w-1:0] data_rd;
    logic                              fill_here;

    assign fill_here = fill_en && (victim_way == 1'(w));

    always_ff @(posedge clk) begin
      if (sweeping) begin
        valid_mem[set_index] <= 1'b0;
      end else if (fill_here) begin
        valid_mem[set_index] <= 1'b1;
        tag_mem[set_index] <= req_q.fields.tag;
        data_mem[set_index] <= mem_data;
      end
      if (read_en) begin
        valid_rd <= valid_mem[set_index];
        tag_rd <= tag_mem[set_index];
        data_rd <= data_mem[set_index];
      end
    end

    assign way_hit[w] = valid_rd && (tag_rd == req_q.fields.tag);
  end

  assign hit = |way_hit;
  assign hit_way = way_hit[1];

  assign line_word = way_hit[1] ? g_way[1].data_rd : g_way[0].data_rd;

  // big endian within the word so offset 0 is the top byte
  assign byte_sel = ~req_q.fields.offset;
  assign rsp_data = line_word[byte_sel*cache_geom_pkg::byte_w +: cache_geom_pkg::byte_w];

  // word address is the byte address without its offset bits
  assign miss_addr = req_q.raw[cache_geom_pkg::addr_w-1:cache_geom_pkg::offset_w];

endmodule

`default_nettype wire

//--- hw/lru_store.sv
// One replacement bit per set naming the way to evict next.
// A read that meets a write to the same set returns the new value.
`default_nettype none

module lru_store (
  input  logic                   clk,
  input  cache_geom_pkg::index_t read_index,
  input  logic                   read_en,
  input  cache_geom_pkg::index_t write_index,
  input  logic                   write_en,
  input  logic                   used_way,
  input  logic                   clear,
  output logic                   victim_way
);

  logic lru_mem [cache_geom_pkg::num_sets];
  logic wr;
  logic wr_bit;

  assign wr = write_en || clear;

  // after a clear way 0 goes first, otherwise the way not just used
  assign wr_bit = clear ? 1'b0 : ~used_way;

  always_ff @(posedge clk) begin
    if (wr) begin
      lru_mem[write_index] <= wr_bit;
    end
    if (read_en) begin
      // bypass so back-to-back requests to one set see the update
      if (wr && (write_index == read_index)) begin
        victim_way <= wr_bit;
      end else begin
        victim_way <= lru_mem[read_index];
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/sweep_counter.sv
// Walks the set index once through all sets after reset so the cache
// can invalidate every line, then parks at the end.
`default_nettype none

module sweep_counter (
  input  logic                   clk,
  input  logic                   rst,
  output cache_geom_pkg::index_t sweep_index,
  output logic                   sweep_done
);

  // one extra bit marks that every set has been visited
  logic [cache_geom_pkg::index_w:0] cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt <= '0;
    end else if (!cnt[cache_geom_pkg::index_w]) begin
      cnt <= cnt + 1'b1;
    end
  end

  assign sweep_index = cnt[cache_geom_pkg::index_w-1:0];

  // high while the last set is cleared, so the controller
  // leaves the sweep right after it
  assign sweep_done = (int'(cnt) >= cache_geom_pkg::num_sets - 1);

endmodule

`default_nettype wire

//--- hw/cache_bus_pkg.sv
// Port structs for the client and memory sides of the read cache,
// plus the controller state encoding shared with the protocol checker.
`default_nettype none

package cache_bus_pkg;

  // client request payload, valid and ready are separate ports
  typedef struct packed {
    cache_geom_pkg::cache_addr_t addr;
  } cache_req_t;

  // client response payload
  typedef struct packed {
    logic [cache_geom_pkg::byte_w-1:0] data;
  } cache_rsp_t;

  // strobe is held high until the acknowledge
  typedef struct packed {
    logic                                  stb;
    logic [cache_geom_pkg::mem_addr_w-1:0] addr;
  } mem_req_t;

  // single cycle acknowledge, data valid with it
  typedef struct packed {
    logic                              ack;
    logic [cache_geom_pkg::word_w-1:0] data;
  } mem_rsp_t;

  typedef enum logic [1:0] {
    st_sweep     = 2'd0,
    st_run       = 2'd1,
    st_miss_wait = 2'd2,
    st_refill    = 2'd3
  } fsm_state_t;

endpackage

`default_nettype wire

//--- hw/cache_geom_pkg.sv
// Geometry of the two-way read cache and the layout of a request address.
// Modules refer to these definitions by scoped names.
`default_nettype none

package cache_geom_pkg;

  // address split: tag | index | byte offset
  localparam int tag_w = 9;
  localparam int index_w = 5;
  localparam int offset_w = 2;
  localparam int addr_w = tag_w + index_w + offset_w;

  localparam int num_sets = 32;

  // one word per line, one byte per response
  localparam int word_w = 32;
  localparam int byte_w = 8;

  // memory is word addressed, so the offset is dropped
  localparam int mem_addr_w = tag_w + index_w;

  typedef logic [tag_w-1:0] tag_t;
  typedef logic [index_w-1:0] index_t;
  typedef logic [offset_w-1:0] offset_t;

  typedef struct packed {
    tag_t    tag;
    index_t  index;
    offset_t offset;
  } addr_fields_t;

  // same 16 bits, seen as a flat byte address or as cache fields
  typedef union packed {
    logic [addr_w-1:0] raw;
    addr_fields_t      fields;
  } cache_addr_t;

endpackage

`default_nettype wire
